// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = lcd_tb
FILELIST = tb.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/lcd_stimulus.txt ====
// line 1: {expected host beat count [31:16], command word count [15:0]}
// then the command words (32 bits), then the expected host beats {rs, data[15:0]}
000F0009
0000002A // instruction 0x002A
40000000 // data 0x0000
400000EF // data 0x00EF
8000F800 // fill, count 0
800107E0 // fill, count 1
8006001F // fill, count 6, longer than the buffer
0000002C // instruction 0x002C
8003FFFF // fill, count 3
40001234 // data 0x1234
0002A
10000
100EF
107E0
1001F
1001F
1001F
1001F
1001F
1001F
0002C
1FFFF
1FFFF
1FFFF
11234

// ==== dv/lcd_tb.sv ====
// default lcd_top parameters only; run from the project root so dv/lcd_stimulus.txt is found
`timescale 1ns/1ps
`default_nettype none

module lcd_tb
    import lcd_pkg::*;
;

    `include "lcd_init_table.svh"

    localparam int FIFO_DEPTH        = 4;
    localparam int WR_LOW_CYCLES     = 2;
    localparam int RESET_HOLD_CYCLES = 8;

    logic                  pclk;
    logic                  rst_n;
    logic                  cmd_valid_i;
    cmd_word_t             cmd_i;
    logic                  credit_o;
    logic                  init_done_o;
    logic                  lcd_rst_o;
    logic                  lcd_cs_o;
    logic                  lcd_rs_o;
    logic                  lcd_wr_o;
    logic [LCD_DATA_W-1:0] lcd_data_o;

    logic [31:0] stim_mem [0:63];
    int          nwords;
    int          nbeats;
    int          sent = 0;
    int          returned = 0;
    int          beat_idx = 0;
    int          hold_cnt = 0;
    int          low_cnt = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;
    logic        rst_seen_high = 1'b0;
    logic        wr_prev = 1'b1;
    logic        hold_rs;
    logic [15:0] hold_data;
    logic [15:0] lfsr_q = 16'd28585;

    lcd_top dut_i (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .cmd_valid_i(cmd_valid_i),
        .cmd_i      (cmd_i),
        .credit_o   (credit_o),
        .init_done_o(init_done_o),
        .lcd_rst_o  (lcd_rst_o),
        .lcd_cs_o   (lcd_cs_o),
        .lcd_rs_o   (lcd_rs_o),
        .lcd_wr_o   (lcd_wr_o),
        .lcd_data_o (lcd_data_o)
    );

    always #50 pclk = ~pclk;

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    task automatic compare_word(input string test_name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (expected == actual) else begin
            value_errs++;
            $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // expected beat for the next capture, init table first then host beats
    task automatic check_beat();
        logic [31:0] actual;
        actual = {15'b0, lcd_rs_o, lcd_data_o};
        if (beat_idx < INIT_LEN) begin
            compare_word($sformatf("init_beat %0d", beat_idx), 32'(lcd_init_entry(beat_idx)),
                         actual);
        end else if (beat_idx < INIT_LEN + nbeats) begin
            assert (init_done_o) else begin
                other_errs++;
                $display("init_done_o still low at host beat %0d", beat_idx - INIT_LEN);
            end
            compare_word($sformatf("host_beat %0d", beat_idx - INIT_LEN),
                         {15'b0, stim_mem[1 + nwords + beat_idx - INIT_LEN][16:0]}, actual);
        end else begin
            assert (1'b0) else begin
                other_errs++;
                $display("unexpected extra beat %h on the panel bus", actual);
            end
        end
        beat_idx++;
    endtask

    // dut outputs sampled mid-cycle
    always @(negedge pclk) begin
        if (!rst_n) begin
            assert (lcd_cs_o && lcd_wr_o && !lcd_rst_o && !credit_o && !init_done_o) else begin
                other_errs++;
                $display("outputs not at their idle values while reset is asserted");
            end
        end else begin
            if (credit_o) returned++;
            assert (FIFO_DEPTH - sent + returned >= 0 && FIFO_DEPTH - sent + returned <= FIFO_DEPTH)
            else begin
                other_errs++;
                $display("host credit count out of range: %0d", FIFO_DEPTH - sent + returned);
            end
            if (!rst_seen_high) begin
                if (!lcd_rst_o) begin
                    hold_cnt++;
                    assert (lcd_cs_o && lcd_wr_o && !init_done_o) else begin
                        other_errs++;
                        $display("bus active or init done while the panel is held in reset");
                    end
                end else begin
                    rst_seen_high = 1'b1;
                    compare_word("reset_hold", RESET_HOLD_CYCLES, hold_cnt);
                end
            end else begin
                assert (lcd_rst_o) else begin
                    other_errs++;
                    $display("panel reset went low again after release");
                end
            end
            if (!lcd_wr_o) begin
                assert (!lcd_cs_o) else begin
                    other_errs++;
                    $display("write strobe low while chip select is high");
                end
                if (wr_prev) begin
                    hold_rs   = lcd_rs_o;
                    hold_data = lcd_data_o;
                    low_cnt   = 1;
                end else begin
                    low_cnt++;
                    assert (lcd_rs_o == hold_rs && lcd_data_o == hold_data) else begin
                        other_errs++;
                        $display("rs or data changed while the write strobe was low");
                    end
                end
            end else if (!wr_prev) begin // panel latched on this rise
                compare_word("wr_low_width", WR_LOW_CYCLES, low_cnt);
                assert (!lcd_cs_o) else begin
                    other_errs++;
                    $display("chip select high at the write strobe rising edge");
                end
                check_beat();
            end
            wr_prev = lcd_wr_o;
        end
    end

    always @(posedge pclk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: test did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [1:0] gap;
        pclk        = 1'b0;
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        $readmemh("dv/lcd_stimulus.txt", stim_mem);
        nwords      = int'(stim_mem[0][15:0]);
        nbeats      = int'(stim_mem[0][31:16]);
        cycle_limit = RESET_HOLD_CYCLES + (INIT_LEN + nbeats) * 4 + 200 + 4 * nwords;
        repeat (4) @(posedge pclk);
        rst_n <= 1'b1;
        for (int w = 0; w < nwords; w++) begin
            take_bit(gap[0]);
            take_bit(gap[1]);
            repeat (int'(gap)) @(posedge pclk);
            while (FIFO_DEPTH - sent + returned <= 0) @(posedge pclk); // no credit held
            cmd_valid_i <= 1'b1;
            cmd_i       <= stim_mem[1 + w];
            sent++;
            @(posedge pclk);
            cmd_valid_i <= 1'b0;
        end
        while (beat_idx < INIT_LEN + nbeats || returned < nwords) @(posedge pclk);
        repeat (20) @(posedge pclk); // room for stray beats or credits
        compare_word("credit_total", sent, returned);
        compare_word("beat_total", INIT_LEN + nbeats, beat_idx);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/lcd_init_table.svh ====
// needs lcd_pkg imported in the including scope; entries play back to back with no delays
function automatic lcd_beat_t lcd_init_entry(input int idx);
    lcd_beat_t entry;
    case (idx)
        0:       entry = '{rs: 1'b0, data: 16'h0001}; // software reset
        1:       entry = '{rs: 1'b0, data: 16'h0011}; // sleep out
        2:       entry = '{rs: 1'b0, data: 16'h003A}; // pixel format
        3:       entry = '{rs: 1'b1, data: 16'h0055}; // 16 bpp
        4:       entry = '{rs: 1'b0, data: 16'h0036}; // memory access ctrl
        5:       entry = '{rs: 1'b0, data: 16'h0029}; // display on
        default: entry = '0;
    endcase
    return entry;
endfunction

// ==== tb.f ====
+incdir+include
verilog/lcd_pkg.sv
verilog/lcd_cmd_fifo.sv
verilog/lcd_refresh.sv
verilog/lcd_init.sv
verilog/lcd_bus_writer.sv
verilog/lcd_top.sv
dv/lcd_tb.sv

// ==== verilog/lcd_bus_writer.sv ====
// write-only 8080 bus; WR_LOW_CYCLES and WR_HIGH_CYCLES must each be at least 1
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer
    import lcd_pkg::*;
#(
    parameter int WR_LOW_CYCLES  = 2,
    parameter int WR_HIGH_CYCLES = 2
) (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic                  init_valid_i,
    input  lcd_beat_t             init_beat_i,
    output logic                  init_ready_o,
    input  logic                  init_done_i,
    input  logic                  refresh_valid_i,
    input  lcd_beat_t             refresh_beat_i,
    output logic                  refresh_ready_o,
    output logic                  lcd_cs_o,
    output logic                  lcd_rs_o,
    output logic                  lcd_wr_o,
    output logic [LCD_DATA_W-1:0] lcd_data_o
);

    localparam int BEAT_CYCLES = WR_LOW_CYCLES + WR_HIGH_CYCLES;
    localparam int PH_W        = (BEAT_CYCLES > 1) ? $clog2(BEAT_CYCLES) : 1;

    logic [PH_W-1:0] phase_q;
    lcd_beat_t       beat_q;
    logic            busy;
    logic            last;
    logic            can_take;
    logic            src_valid;
    lcd_beat_t       src_beat;
    logic            take;

    assign busy     = !lcd_cs_o;
    assign last     = busy && (phase_q == PH_W'(BEAT_CYCLES - 1));
    assign can_take = !busy || last; // back to back, no idle cycle

    // init owns the bus until it reports done
    assign src_valid       = init_done_i ? refresh_valid_i : init_valid_i;
    assign src_beat        = init_done_i ? refresh_beat_i : init_beat_i;
    assign init_ready_o    = can_take && !init_done_i;
    assign refresh_ready_o = can_take && init_done_i;
    assign take            = can_take && src_valid;

    assign lcd_rs_o   = beat_q.rs;
    assign lcd_data_o = beat_q.data;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            lcd_cs_o <= 1'b1;
            lcd_wr_o <= 1'b1;
            phase_q  <= '0;
        end else if (take) begin
            lcd_cs_o <= 1'b0;
            lcd_wr_o <= 1'b0;
            phase_q  <= '0;
        end else if (busy) begin
            phase_q <= phase_q + 1'b1;
            // panel latches on this rising edge
            if (phase_q == PH_W'(WR_LOW_CYCLES - 1)) lcd_wr_o <= 1'b1;
            if (last) begin
                lcd_cs_o <= 1'b1;
                phase_q  <= '0;
            end
        end
    end

    // rs and data held for the whole beat
    always_ff @(posedge pclk) begin
        if (take) beat_q <= src_beat;
    end

endmodule

`default_nettype wire

// ==== verilog/lcd_cmd_fifo.sv ====
// host must respect credits; a push into a full buffer is silently lost
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_fifo
    import lcd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      cmd_valid_i,
    input  cmd_word_t cmd_i,
    output logic      credit_o,
    output logic      fifo_valid_o,
    output cmd_word_t fifo_word_o,
    input  logic      fifo_ready_i
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cmd_word_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push         = cmd_valid_i && (count_q != CNT_W'(FIFO_DEPTH));
    assign fifo_valid_o = (count_q != '0);
    assign pop          = fifo_valid_o && fifo_ready_i;
    assign credit_o     = pop; // one credit back per word handed on
    assign fifo_word_o  = mem_q[rd_ptr_q];

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge pclk) begin
        if (push) mem_q[wr_ptr_q] <= cmd_i;
    end

endmodule

`default_nettype wire

// ==== verilog/lcd_init.sv ====
// RESET_HOLD_CYCLES must be at least 1; table plays once per reset with no settle delays
`timescale 1ns/1ps
`default_nettype none

module lcd_init
    import lcd_pkg::*;
#(
    parameter int RESET_HOLD_CYCLES = 8
) (
    input  logic      pclk,
    input  logic      rst_n,
    output logic      lcd_rst_o,
    output logic      beat_valid_o,
    output lcd_beat_t beat_o,
    input  logic      beat_ready_i,
    output logic      init_done_o
);

    `include "lcd_init_table.svh"

    localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);
    localparam int IDX_W  = $clog2(INIT_LEN);

    logic [HOLD_W-1:0] hold_q;
    logic [IDX_W-1:0]  idx_q;
    logic              step;

    // table only runs once the panel is out of reset
    assign beat_valid_o = lcd_rst_o && !init_done_o;
    assign step         = beat_valid_o && beat_ready_i;

    always_comb begin
        beat_o = lcd_init_entry(int'(idx_q));
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            hold_q      <= '0;
            lcd_rst_o   <= 1'b0;
            idx_q       <= '0;
            init_done_o <= 1'b0;
        end else begin
            if (!lcd_rst_o) begin
                hold_q <= hold_q + 1'b1;
                if (hold_q == HOLD_W'(RESET_HOLD_CYCLES - 1)) lcd_rst_o <= 1'b1;
            end
            if (step) begin
                if (idx_q == IDX_W'(INIT_LEN - 1)) init_done_o <= 1'b1; // sticky
                else                               idx_q       <= idx_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lcd_pkg.sv ====
// command and beat layouts are fixed at a 16-bit panel bus; widths here must match the host's encoder
`default_nettype none

package lcd_pkg;

    localparam int LCD_DATA_W   = 16;
    localparam int FILL_COUNT_W = 15;
    localparam int INIT_LEN     = 6;

    localparam logic CMD_KIND_FILL = 1'b1; // bit 31, same place in both views

    // one write on the panel bus
    typedef struct packed {
        logic                  rs;   // 0 instruction, 1 data
        logic [LCD_DATA_W-1:0] data;
    } lcd_beat_t;

    // register view, one word straight to the panel
    typedef struct packed {
        logic                  kind;
        logic                  rs;
        logic [13:0]           unused;
        logic [LCD_DATA_W-1:0] data;
    } cmd_reg_t;

    // fill view, repeat a color count times
    typedef struct packed {
        logic                    kind;
        logic [FILL_COUNT_W-1:0] count;
        logic [LCD_DATA_W-1:0]   color;
    } cmd_fill_t;

    // host command word, decoded by kind
    typedef union packed {
        cmd_reg_t  regv;
        cmd_fill_t fill;
    } cmd_word_t;

endpackage

`default_nettype wire

// ==== verilog/lcd_refresh.sv ====
// fill runs up to 32767 pixels of one color; a zero count is dropped without a beat
`timescale 1ns/1ps
`default_nettype none

module lcd_refresh
    import lcd_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n,
    input  logic      fifo_valid_i,
    input  cmd_word_t fifo_word_i,
    output logic      fifo_ready_o,
    output logic      beat_valid_o,
    output lcd_beat_t beat_o,
    input  logic      beat_ready_i
);

    logic                    pend_q;  // a beat is on offer
    logic [FILL_COUNT_W-1:0] left_q;  // beats still to come after this one
    lcd_beat_t               beat_q;
    logic                    take;
    logic                    beat_done;
    logic                    is_fill;
    lcd_beat_t               load_beat;

    // free now, or the last beat of the run leaves this cycle
    assign fifo_ready_o = !pend_q || (beat_ready_i && (left_q == '0));
    assign take         = fifo_valid_i && fifo_ready_o;
    assign beat_done    = pend_q && beat_ready_i;
    assign beat_valid_o = pend_q;
    assign beat_o       = beat_q;

    always_comb begin
        is_fill = (fifo_word_i.fill.kind == CMD_KIND_FILL);
        if (is_fill) begin
            load_beat.rs   = 1'b1;                  // pixels are always data
            load_beat.data = fifo_word_i.fill.color;
        end else begin
            load_beat.rs   = fifo_word_i.regv.rs;
            load_beat.data = fifo_word_i.regv.data;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            left_q <= '0;
        end else if (take) begin
            if (is_fill) begin
                pend_q <= (fifo_word_i.fill.count != '0);
                left_q <= (fifo_word_i.fill.count != '0) ? fifo_word_i.fill.count - 1'b1 : '0;
            end else begin
                pend_q <= 1'b1;
                left_q <= '0;
            end
        end else if (beat_done) begin
            if (left_q != '0) left_q <= left_q - 1'b1;
            else              pend_q <= 1'b0;
        end
    end

    // color stays put for the whole run
    always_ff @(posedge pclk) begin
        if (take) beat_q <= load_beat;
    end

endmodule

`default_nettype wire

// ==== verilog/lcd_top.sv ====
// single clock; host sends only while holding a credit, starting with FIFO_DEPTH after reset
`timescale 1ns/1ps
`default_nettype none

module lcd_top
    import lcd_pkg::*;
#(
    parameter int FIFO_DEPTH        = 4,
    parameter int WR_LOW_CYCLES     = 2,
    parameter int WR_HIGH_CYCLES    = 2,
    parameter int RESET_HOLD_CYCLES = 8
) (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic                  cmd_valid_i,
    input  cmd_word_t             cmd_i,
    output logic                  credit_o,
    output logic                  init_done_o,
    output logic                  lcd_rst_o,
    output logic                  lcd_cs_o,
    output logic                  lcd_rs_o,
    output logic                  lcd_wr_o,
    output logic [LCD_DATA_W-1:0] lcd_data_o
);

    logic      fifo_valid;
    cmd_word_t fifo_word;
    logic      fifo_ready;
    logic      refresh_valid;
    lcd_beat_t refresh_beat;
    logic      refresh_ready;
    logic      init_valid;
    lcd_beat_t init_beat;
    logic      init_ready;

    lcd_cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) cmd_fifo_i (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .credit_o    (credit_o),
        .fifo_valid_o(fifo_valid),
        .fifo_word_o (fifo_word),
        .fifo_ready_i(fifo_ready)
    );

    lcd_refresh refresh_i (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .fifo_valid_i(fifo_valid),
        .fifo_word_i (fifo_word),
        .fifo_ready_o(fifo_ready),
        .beat_valid_o(refresh_valid),
        .beat_o      (refresh_beat),
        .beat_ready_i(refresh_ready)
    );

    lcd_init #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) init_i (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .lcd_rst_o   (lcd_rst_o),
        .beat_valid_o(init_valid),
        .beat_o      (init_beat),
        .beat_ready_i(init_ready),
        .init_done_o (init_done_o)
    );

    lcd_bus_writer #(
        .WR_LOW_CYCLES (WR_LOW_CYCLES),
        .WR_HIGH_CYCLES(WR_HIGH_CYCLES)
    ) bus_writer_i (
        .pclk           (pclk),
        .rst_n          (rst_n),
        .init_valid_i   (init_valid),
        .init_beat_i    (init_beat),
        .init_ready_o   (init_ready),
        .init_done_i    (init_done_o),
        .refresh_valid_i(refresh_valid),
        .refresh_beat_i (refresh_beat),
        .refresh_ready_o(refresh_ready),
        .lcd_cs_o       (lcd_cs_o),
        .lcd_rs_o       (lcd_rs_o),
        .lcd_wr_o       (lcd_wr_o),
        .lcd_data_o     (lcd_data_o)
    );

endmodule

`default_nettype wire
